// ==== Bender.yml ====
package:
  name: tblock_dispatch

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/tbd_pkg.sv
      - hdl/alloc_slot.sv
      - hdl/alloc_dispatch.sv
      - hdl/done_collect.sv
      - hdl/tblock_dispatch.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tests/tb_tblock_dispatch.sv

// ==== hdl/alloc_dispatch.sv ====
// ######################################
// Allocate dispatch
// Sends each block to the first free unit
// ######################################

`default_nettype none

`include "tbd_params.svh"

module alloc_dispatch (
    input  logic                                        clk_i,
    input  logic                                        rst_n_i,

    input  logic                                        allocate_warp_i,
    input  tbd_pkg::pc_t                                allocate_pc_i,
    input  tbd_pkg::addr_t                              allocate_dp_addr_i,
    input  tbd_pkg::tblock_idx_t                        allocate_tblock_idx_i,
    input  tbd_pkg::tgroup_id_t                         allocate_tgroup_id_i,
    output logic                                        warp_free_o,

    output tbd_pkg::cu_mask_t                           cu_alloc_valid_o,
    input  tbd_pkg::cu_mask_t                           cu_warp_free_i,
    output tbd_pkg::pc_t         [`TBD_NUM_CU-1:0]      cu_alloc_pc_o,
    output tbd_pkg::addr_t       [`TBD_NUM_CU-1:0]      cu_alloc_dp_addr_o,
    output tbd_pkg::tblock_idx_t [`TBD_NUM_CU-1:0]      cu_alloc_tblock_idx_o,
    output tbd_pkg::tgroup_id_t  [`TBD_NUM_CU-1:0]      cu_alloc_tgroup_id_o
);

    tbd_pkg::alloc_data_t                   alloc_rec;
    tbd_pkg::cu_mask_t                      slot_ready;
    tbd_pkg::cu_mask_t                      slot_valid;
    tbd_pkg::alloc_data_t [`TBD_NUM_CU-1:0] slot_out;

    assign alloc_rec = '{
        pc:         allocate_pc_i,
        dp_addr:    allocate_dp_addr_i,
        tblock_idx: allocate_tblock_idx_i,
        tgroup_id:  allocate_tgroup_id_i
    };

    // An allocate seen with no free slot is simply dropped
    assign warp_free_o = |slot_ready;

    // Lowest-index slot with room wins
    always_comb begin : select_slot
        logic found;
        found      = 1'b0;
        slot_valid = '0;
        for (int unsigned k = 0; k < `TBD_NUM_CU; k++) begin
            if (allocate_warp_i && slot_ready[k] && !found) begin
                slot_valid[k] = 1'b1;
                found         = 1'b1;
            end
        end
    end : select_slot

    for (genvar k = 0; k < `TBD_NUM_CU; k++) begin : gen_slot
        alloc_slot u_alloc_slot (
            .clk_i       (clk_i),
            .rst_n_i     (rst_n_i),
            .in_valid_i  (slot_valid[k]),
            .in_ready_o  (slot_ready[k]),
            .in_data_i   (alloc_rec),
            .out_valid_o (cu_alloc_valid_o[k]),
            .out_ready_i (cu_warp_free_i[k]),
            .out_data_o  (slot_out[k])
        );

        assign cu_alloc_pc_o[k]         = slot_out[k].pc;
        assign cu_alloc_dp_addr_o[k]    = slot_out[k].dp_addr;
        assign cu_alloc_tblock_idx_o[k] = slot_out[k].tblock_idx;
        assign cu_alloc_tgroup_id_o[k]  = slot_out[k].tgroup_id;
    end : gen_slot

endmodule : alloc_dispatch

`default_nettype wire

// ==== hdl/alloc_slot.sv ====
// ######################################
// Allocate slot
// Two-entry spill buffer for one unit
// ######################################

`default_nettype none

module alloc_slot (
    input  logic                 clk_i,
    input  logic                 rst_n_i,

    input  logic                 in_valid_i,
    output logic                 in_ready_o,
    input  tbd_pkg::alloc_data_t in_data_i,

    output logic                 out_valid_o,
    input  logic                 out_ready_i,
    output tbd_pkg::alloc_data_t out_data_o
);

    // Main entry drives the output, spill entry backs it up
    logic                 main_vld_q;
    logic                 spill_vld_q;
    tbd_pkg::alloc_data_t main_q;
    tbd_pkg::alloc_data_t spill_q;

    logic                 push;
    logic                 pop;
    logic                 main_load;
    logic                 spill_load;
    tbd_pkg::alloc_data_t main_d;

    // Spill entry is only ever full when main is full too
    assign in_ready_o  = ~spill_vld_q;
    assign out_valid_o = main_vld_q;
    assign out_data_o  = main_q;

    assign push = in_valid_i & in_ready_o;
    assign pop  = main_vld_q & out_ready_i;

    // Park the new record if main is stalled
    assign spill_load = push & main_vld_q & ~pop;

    // Refill main from spill first to keep arrival order
    assign main_load = (push & (~main_vld_q | pop)) | (spill_vld_q & pop);
    assign main_d    = spill_vld_q ? spill_q : in_data_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            main_vld_q  <= 1'b0;
            spill_vld_q <= 1'b0;
        end else begin
            main_vld_q  <= main_load | (main_vld_q & ~pop);
            spill_vld_q <= spill_load | (spill_vld_q & ~pop);
        end
    end

    always_ff @(posedge clk_i) begin
        if (main_load) begin
            main_q <= main_d;
        end
        if (spill_load) begin
            spill_q <= in_data_i;
        end
    end

endmodule : alloc_slot

`default_nettype wire

// ==== hdl/done_collect.sv ====
// ######################################
// Completion collector
// Round-robin merge of unit done reports
// ######################################

`default_nettype none

`include "tbd_params.svh"

module done_collect (
    input  logic                                      clk_i,
    input  logic                                      rst_n_i,

    input  tbd_pkg::cu_mask_t                         cu_done_i,
    input  tbd_pkg::tgroup_id_t [`TBD_NUM_CU-1:0]     cu_done_id_i,
    output tbd_pkg::cu_mask_t                         cu_done_ready_o,

    output logic                                      tblock_done_o,
    output tbd_pkg::tgroup_id_t                       tblock_done_id_o,
    input  logic                                      tblock_done_ready_i
);

    localparam int unsigned idx_w = (`TBD_NUM_CU > 1) ? $clog2(`TBD_NUM_CU) : 1;

    logic [idx_w-1:0]    rr_ptr_q;
    logic [idx_w-1:0]    grant_idx;
    logic                grant_found;
    tbd_pkg::cu_mask_t   grant;

    logic                out_vld_q;
    tbd_pkg::tgroup_id_t out_id_q;

    // ######################################
    // Arbiter
    // ######################################

    // Search starts at the pointer and wraps around
    always_comb begin : arbitrate
        int unsigned idx;
        idx         = 0;
        grant       = '0;
        grant_idx   = '0;
        grant_found = 1'b0;
        if (!out_vld_q && tblock_done_ready_i) begin
            for (int unsigned off = 0; off < `TBD_NUM_CU; off++) begin
                idx = (32'(rr_ptr_q) + off) % `TBD_NUM_CU;
                if (cu_done_i[idx] && !grant_found) begin
                    grant[idx]  = 1'b1;
                    grant_idx   = idx_w'(idx);
                    grant_found = 1'b1;
                end
            end
        end
    end : arbitrate

    assign cu_done_ready_o = grant;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rr_ptr_q <= '0;
        end else if (grant_found) begin
            // Next search begins just past the winner
            if (grant_idx == idx_w'(`TBD_NUM_CU - 1)) begin
                rr_ptr_q <= '0;
            end else begin
                rr_ptr_q <= grant_idx + 1'b1;
            end
        end
    end

    // ######################################
    // Output register
    // ######################################

    assign tblock_done_o    = out_vld_q;
    assign tblock_done_id_o = out_id_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_vld_q <= 1'b0;
        end else if (grant_found) begin
            out_vld_q <= 1'b1;
        end else if (out_vld_q && tblock_done_ready_i) begin
            out_vld_q <= 1'b0;
        end
    end

    // Loads only while empty, so the ID holds until taken
    always_ff @(posedge clk_i) begin
        if (grant_found) begin
            out_id_q <= cu_done_id_i[grant_idx];
        end
    end

endmodule : done_collect

`default_nettype wire

// ==== hdl/tbd_params.svh ====
// ######################################
// Thread-block dispatch parameters
// Unit count and field widths
// ######################################

`ifndef TBD_PARAMS_SVH
`define TBD_PARAMS_SVH

// ######################################
// Cluster size
// ######################################

// Compute units served by the dispatcher
`define TBD_NUM_CU 4

// ######################################
// Allocate record fields
// ######################################

// Start program counter
`define TBD_PC_WIDTH 16
// Data / parameter pointer
`define TBD_ADDR_WIDTH 32
// Block index inside a thread group
`define TBD_TBLOCK_IDX_BITS 8
// Unique thread group identifier
`define TBD_TGROUP_ID_BITS 8

`endif

// ==== hdl/tbd_pkg.sv ====
// ######################################
// Thread-block dispatch types
// Field types and the allocate record
// ######################################

`default_nettype none

`include "tbd_params.svh"

package tbd_pkg;

    // Record fields
    typedef logic [`TBD_PC_WIDTH-1:0]        pc_t;
    typedef logic [`TBD_ADDR_WIDTH-1:0]      addr_t;
    typedef logic [`TBD_TBLOCK_IDX_BITS-1:0] tblock_idx_t;
    typedef logic [`TBD_TGROUP_ID_BITS-1:0]  tgroup_id_t;

    // One bit per compute unit
    typedef logic [`TBD_NUM_CU-1:0] cu_mask_t;

    // Everything a compute unit needs to start a thread block
    typedef struct packed {
        pc_t         pc;
        addr_t       dp_addr;
        tblock_idx_t tblock_idx;
        tgroup_id_t  tgroup_id;
    } alloc_data_t;

endpackage : tbd_pkg

`default_nettype wire

// ==== hdl/tblock_dispatch.sv ====
// ######################################
// Thread-block dispatch top level
// Allocate fan-out and completion merge
// ######################################

`default_nettype none

`include "tbd_params.svh"

module tblock_dispatch (
    input  logic                                        clk_i,
    input  logic                                        rst_n_i,

    // New thread blocks from the scheduler
    input  logic                                        allocate_warp_i,
    input  tbd_pkg::pc_t                                allocate_pc_i,
    input  tbd_pkg::addr_t                              allocate_dp_addr_i,
    input  tbd_pkg::tblock_idx_t                        allocate_tblock_idx_i,
    input  tbd_pkg::tgroup_id_t                         allocate_tgroup_id_i,
    output logic                                        warp_free_o,

    // Toward the compute units
    output tbd_pkg::cu_mask_t                           cu_alloc_valid_o,
    input  tbd_pkg::cu_mask_t                           cu_warp_free_i,
    output tbd_pkg::pc_t         [`TBD_NUM_CU-1:0]      cu_alloc_pc_o,
    output tbd_pkg::addr_t       [`TBD_NUM_CU-1:0]      cu_alloc_dp_addr_o,
    output tbd_pkg::tblock_idx_t [`TBD_NUM_CU-1:0]      cu_alloc_tblock_idx_o,
    output tbd_pkg::tgroup_id_t  [`TBD_NUM_CU-1:0]      cu_alloc_tgroup_id_o,

    // Completions from the units
    input  tbd_pkg::cu_mask_t                           cu_done_i,
    input  tbd_pkg::tgroup_id_t  [`TBD_NUM_CU-1:0]      cu_done_id_i,
    output tbd_pkg::cu_mask_t                           cu_done_ready_o,

    // Merged completion stream
    output logic                                        tblock_done_o,
    output tbd_pkg::tgroup_id_t                         tblock_done_id_o,
    input  logic                                        tblock_done_ready_i
);

    alloc_dispatch u_alloc_dispatch (
        .clk_i                 (clk_i),
        .rst_n_i               (rst_n_i),
        .allocate_warp_i       (allocate_warp_i),
        .allocate_pc_i         (allocate_pc_i),
        .allocate_dp_addr_i    (allocate_dp_addr_i),
        .allocate_tblock_idx_i (allocate_tblock_idx_i),
        .allocate_tgroup_id_i  (allocate_tgroup_id_i),
        .warp_free_o           (warp_free_o),
        .cu_alloc_valid_o      (cu_alloc_valid_o),
        .cu_warp_free_i        (cu_warp_free_i),
        .cu_alloc_pc_o         (cu_alloc_pc_o),
        .cu_alloc_dp_addr_o    (cu_alloc_dp_addr_o),
        .cu_alloc_tblock_idx_o (cu_alloc_tblock_idx_o),
        .cu_alloc_tgroup_id_o  (cu_alloc_tgroup_id_o)
    );

    done_collect u_done_collect (
        .clk_i               (clk_i),
        .rst_n_i             (rst_n_i),
        .cu_done_i           (cu_done_i),
        .cu_done_id_i        (cu_done_id_i),
        .cu_done_ready_o     (cu_done_ready_o),
        .tblock_done_o       (tblock_done_o),
        .tblock_done_id_o    (tblock_done_id_o),
        .tblock_done_ready_i (tblock_done_ready_i)
    );

endmodule : tblock_dispatch

`default_nettype wire

// ==== tblock_dispatch.f ====
+incdir+hdl
hdl/tbd_pkg.sv
hdl/alloc_slot.sv
hdl/alloc_dispatch.sv
hdl/done_collect.sv
hdl/tblock_dispatch.sv
tests/tb_tblock_dispatch.sv

// ==== tests/tb_tblock_dispatch.sv ====
// ########################################
// Thread-block dispatch testbench
// Table-driven, with compute unit models
// ########################################

`default_nettype none

`include "tbd_params.svh"

module tb_tblock_dispatch;

    localparam int n_cu = `TBD_NUM_CU;
    localparam int clk_period = 40;

    // Row operations and expected warp_free_o codes
    localparam logic [2:0] op_alloc = 3'd0;
    localparam logic [2:0] op_ready = 3'd1;
    localparam logic [2:0] op_done = 3'd2;
    localparam logic [2:0] op_out_ready = 3'd3;
    localparam logic [2:0] op_idle = 3'd4;
    localparam logic [1:0] free_no = 2'd0;
    localparam logic [1:0] free_yes = 2'd1;
    localparam logic [1:0] free_any = 2'd2;

    typedef struct packed {
        logic [2:0] op;
        logic [7:0] arg;
        logic [1:0] exp_free;
    } row_t;

    logic                                clk = 1'b0;
    logic                                rst_n = 1'b0;
    logic                                allocate_warp = 1'b0;
    tbd_pkg::pc_t                        allocate_pc = '0;
    tbd_pkg::addr_t                      allocate_dp_addr = '0;
    tbd_pkg::tblock_idx_t                allocate_tblock_idx = '0;
    tbd_pkg::tgroup_id_t                 allocate_tgroup_id = '0;
    logic                                warp_free;
    tbd_pkg::cu_mask_t                   cu_alloc_valid;
    tbd_pkg::cu_mask_t                   cu_warp_free = '0;
    tbd_pkg::pc_t         [n_cu-1:0]     cu_alloc_pc;
    tbd_pkg::addr_t       [n_cu-1:0]     cu_alloc_dp_addr;
    tbd_pkg::tblock_idx_t [n_cu-1:0]     cu_alloc_tblock_idx;
    tbd_pkg::tgroup_id_t  [n_cu-1:0]     cu_alloc_tgroup_id;
    tbd_pkg::cu_mask_t                   cu_done = '0;
    tbd_pkg::tgroup_id_t  [n_cu-1:0]     cu_done_id = '0;
    tbd_pkg::cu_mask_t                   cu_done_ready;
    logic                                tblock_done;
    tbd_pkg::tgroup_id_t                 tblock_done_id;
    logic                                tblock_done_ready = 1'b0;

    // Scoreboard and unit model state
    tbd_pkg::alloc_data_t exp_alloc [n_cu][$];
    int unsigned          rr_ptr = 0;
    logic                 out_vld = 1'b0;
    tbd_pkg::tgroup_id_t  out_id = '0;
    int                   done_asked [n_cu] = '{default: 0};
    int                   done_raised [n_cu] = '{default: 0};
    tbd_pkg::tgroup_id_t  done_next_id [n_cu] = '{default: '0};
    int                   done_reported = 0;
    integer               seed = 32'hd3c977c1;
    row_t                 rows [$];
    int                   table_len = 0;

    always #(clk_period / 2) clk = ~clk;

    tblock_dispatch u_dut (
        .clk_i                 (clk),
        .rst_n_i               (rst_n),
        .allocate_warp_i       (allocate_warp),
        .allocate_pc_i         (allocate_pc),
        .allocate_dp_addr_i    (allocate_dp_addr),
        .allocate_tblock_idx_i (allocate_tblock_idx),
        .allocate_tgroup_id_i  (allocate_tgroup_id),
        .warp_free_o           (warp_free),
        .cu_alloc_valid_o      (cu_alloc_valid),
        .cu_warp_free_i        (cu_warp_free),
        .cu_alloc_pc_o         (cu_alloc_pc),
        .cu_alloc_dp_addr_o    (cu_alloc_dp_addr),
        .cu_alloc_tblock_idx_o (cu_alloc_tblock_idx),
        .cu_alloc_tgroup_id_o  (cu_alloc_tgroup_id),
        .cu_done_i             (cu_done),
        .cu_done_id_i          (cu_done_id),
        .cu_done_ready_o       (cu_done_ready),
        .tblock_done_o         (tblock_done),
        .tblock_done_id_o      (tblock_done_id),
        .tblock_done_ready_i   (tblock_done_ready)
    );

    // ########################################
    // Compare tasks
    // ########################################

    task automatic abort_run(input string line);
        $display("%s", line);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("FAIL %0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    task automatic check_mask(input tbd_pkg::cu_mask_t got, input tbd_pkg::cu_mask_t exp,
                              input string what);
        if (got !== exp) begin
            abort_run($sformatf("FAIL %0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    task automatic check_alloc(input tbd_pkg::alloc_data_t got,
                               input tbd_pkg::alloc_data_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("FAIL %0t: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_done_id(input tbd_pkg::tgroup_id_t got,
                                 input tbd_pkg::tgroup_id_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("FAIL %0t: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    // ########################################
    // Compute unit models and scoreboard
    // ########################################

    always @(posedge clk) begin : unit_models
        tbd_pkg::cu_mask_t    exp_valid;
        tbd_pkg::cu_mask_t    exp_grant;
        tbd_pkg::alloc_data_t rec;
        int                   target;
        int unsigned          k;
        if (rst_n) begin
            // Slot occupancy is taken before this edge's transfers
            target    = -1;
            exp_valid = '0;
            for (int i = 0; i < n_cu; i++) begin
                exp_valid[i] = (exp_alloc[i].size() != 0);
                if (target < 0 && exp_alloc[i].size() < 2) begin
                    target = i;
                end
            end
            check_flag(warp_free, target >= 0, "warp_free_o");
            check_mask(cu_alloc_valid, exp_valid, "cu_alloc_valid_o");
            for (int i = 0; i < n_cu; i++) begin
                if (cu_alloc_valid[i] && cu_warp_free[i]) begin
                    rec = '{cu_alloc_pc[i], cu_alloc_dp_addr[i], cu_alloc_tblock_idx[i],
                            cu_alloc_tgroup_id[i]};
                    check_alloc(rec, exp_alloc[i].pop_front(), $sformatf("record at unit %0d", i));
                end
            end
            // Allocations seen while no slot is free are lost
            if (allocate_warp && target >= 0) begin
                rec = '{allocate_pc, allocate_dp_addr, allocate_tblock_idx, allocate_tgroup_id};
                exp_alloc[target].push_back(rec);
            end

            // Round-robin grant, only into an empty output register
            exp_grant = '0;
            if (!out_vld && tblock_done_ready) begin
                for (int unsigned off = 0; off < n_cu; off++) begin
                    k = (rr_ptr + off) % n_cu;
                    if (cu_done[k] && exp_grant == '0) begin
                        exp_grant[k] = 1'b1;
                    end
                end
            end
            check_mask(cu_done_ready, exp_grant, "cu_done_ready_o");
            check_flag(tblock_done, out_vld, "tblock_done_o");
            if (out_vld) begin
                check_done_id(tblock_done_id, out_id, "tblock_done_id_o");
            end
            if (out_vld && tblock_done_ready) begin
                out_vld = 1'b0;
                done_reported++;
            end
            for (int i = 0; i < n_cu; i++) begin
                if (exp_grant[i]) begin
                    out_vld     = 1'b1;
                    out_id      = cu_done_id[i];
                    rr_ptr      = (i + 1) % n_cu;
                    cu_done[i] <= 1'b0;
                end else if (!cu_done[i] && done_raised[i] < done_asked[i]) begin
                    cu_done[i]    <= 1'b1;
                    cu_done_id[i] <= done_next_id[i];
                    done_raised[i]++;
                end
            end
        end
    end : unit_models

    // ########################################
    // Stimulus
    // ########################################

    task automatic add_row(input logic [2:0] op, input logic [7:0] arg, input logic [1:0] exp);
        rows.push_back({op, arg, exp});
    endtask

    task automatic issue_allocs(input int count);
        repeat (count) begin
            @(posedge clk);
            allocate_warp       <= 1'b1;
            allocate_pc         <= tbd_pkg::pc_t'($random(seed));
            allocate_dp_addr    <= tbd_pkg::addr_t'($random(seed));
            allocate_tblock_idx <= tbd_pkg::tblock_idx_t'($random(seed));
            allocate_tgroup_id  <= tbd_pkg::tgroup_id_t'($random(seed));
        end
        @(posedge clk);
        allocate_warp <= 1'b0;
    endtask

    task automatic ask_done(input tbd_pkg::cu_mask_t mask);
        @(posedge clk);
        for (int i = 0; i < n_cu; i++) begin
            if (mask[i]) begin
                done_next_id[i] <= tbd_pkg::tgroup_id_t'($random(seed));
                done_asked[i]   <= done_asked[i] + 1;
            end
        end
    endtask

    task automatic build_table();
        add_row(op_ready, 8'hf, free_any);
        add_row(op_out_ready, 8'h1, free_any);
        add_row(op_idle, 8'd2, free_yes);
        add_row(op_alloc, 8'd6, free_any);
        add_row(op_idle, 8'd3, free_yes);
        // Stalled units fill every slot, then extra allocations drop
        add_row(op_ready, 8'h0, free_any);
        add_row(op_idle, 8'd2, free_yes);
        add_row(op_alloc, 8'(2 * n_cu), free_any);
        add_row(op_idle, 8'd1, free_no);
        add_row(op_alloc, 8'd3, free_any);
        add_row(op_idle, 8'd2, free_no);
        add_row(op_ready, 8'h4, free_any);
        add_row(op_idle, 8'd2, free_yes);
        add_row(op_alloc, 8'd2, free_any);
        add_row(op_ready, 8'hf, free_any);
        add_row(op_idle, 8'd4, free_yes);
        // Simultaneous completions
        add_row(op_done, 8'hf, free_any);
        add_row(op_idle, 8'd12, free_yes);
        add_row(op_done, 8'h2, free_any);
        add_row(op_idle, 8'd4, free_any);
        add_row(op_done, 8'hb, free_any);
        add_row(op_idle, 8'd10, free_any);
        // Outside stalls just as the first grant lands
        add_row(op_done, 8'h5, free_any);
        add_row(op_idle, 8'd1, free_any);
        add_row(op_out_ready, 8'h0, free_any);
        add_row(op_idle, 8'd6, free_any);
        add_row(op_out_ready, 8'h1, free_any);
        add_row(op_idle, 8'd8, free_any);
        // Mixed traffic
        add_row(op_ready, 8'h5, free_any);
        add_row(op_alloc, 8'd5, free_any);
        add_row(op_done, 8'ha, free_any);
        add_row(op_idle, 8'd16, free_yes);
        add_row(op_ready, 8'hf, free_any);
        add_row(op_idle, 8'd8, free_yes);
    endtask

    initial begin : run_table
        int asked_total;
        build_table();
        table_len = rows.size();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_flag(warp_free, 1'b1, "warp_free_o after reset");
        check_mask(cu_alloc_valid, '0, "cu_alloc_valid_o after reset");
        check_mask(cu_done_ready, '0, "cu_done_ready_o after reset");
        check_flag(tblock_done, 1'b0, "tblock_done_o after reset");
        foreach (rows[r]) begin
            case (rows[r].op)
                op_alloc: issue_allocs(rows[r].arg);
                op_ready: begin
                    @(posedge clk);
                    cu_warp_free <= rows[r].arg[n_cu-1:0];
                end
                op_done: ask_done(rows[r].arg[n_cu-1:0]);
                op_out_ready: begin
                    @(posedge clk);
                    tblock_done_ready <= rows[r].arg[0];
                end
                default: repeat (rows[r].arg) @(posedge clk);
            endcase
            if (rows[r].exp_free != free_any) begin
                check_flag(warp_free, rows[r].exp_free[0], $sformatf("warp_free_o, row %0d", r));
            end
        end
        asked_total = 0;
        for (int i = 0; i < n_cu; i++) begin
            asked_total += done_asked[i];
            check_flag(exp_alloc[i].size() == 0, 1'b1, $sformatf("unit %0d drained", i));
        end
        check_flag(done_reported == asked_total, 1'b1, "every completion reported once");
        $display(">>> PASS");
        $finish;
    end : run_table

    initial begin : watchdog
        wait (table_len > 0);
        #(table_len * 16 * clk_period);
        abort_run("Timeout: the stimulus table did not finish in the allowed time");
    end : watchdog

endmodule : tb_tblock_dispatch

`default_nettype wire
